// File: rtl/periph_bus_pkg.sv
////////////////////////////////////////////////////////////
// Peripheral bus types
// Access size codes, the core request and the response
// returned by every full-interface peripheral
////////////////////////////////////////////////////////////
`default_nettype none

package periph_bus_pkg;

    localparam int unsigned ADDR_W = 11;
    localparam int unsigned DATA_W = 32;

    // Matches the core's two-bit read and write codes
    typedef enum logic [1:0] {
        acc_byte = 2'b00,
        acc_half = 2'b01,
        acc_word = 2'b10,
        acc_none = 2'b11
    } access_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] wdata;
        access_size_e      write;
        access_size_e      read;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
    } periph_resp_t;

endpackage

`default_nettype wire

// File: rtl/periph_map_pkg.sv
////////////////////////////////////////////////////////////
// Peripheral address map
// Slot numbers, register offsets and timer state
////////////////////////////////////////////////////////////
`default_nettype none

package periph_map_pkg;

    localparam int unsigned NUM_USER   = 4;
    localparam int unsigned NUM_SIMPLE = 2;

    localparam int unsigned SLOT_GPIO  = 1;
    localparam int unsigned SLOT_TIMER = 2;
    localparam int unsigned SIMPLE_PWM = 0;

    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;

    localparam logic [5:0] TMR_CMP_OFS  = 6'h00;
    localparam logic [5:0] TMR_CTRL_OFS = 6'h04;
    localparam logic [5:0] TMR_CNT_OFS  = 6'h08;

    // Set in a pin source code to pick a simple slot
    localparam int unsigned SRC_SIMPLE_BIT = 4;

    typedef enum logic {
        tmr_idle    = 1'b0,
        tmr_running = 1'b1
    } timer_state_e;

endpackage

`default_nettype wire

// File: rtl/periph_decode.sv
////////////////////////////////////////////////////////////
// Peripheral address decode
// Slot select vectors and per-slot gated requests
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_decode (
    input  periph_bus_pkg::bus_req_t                req,
    output logic [periph_map_pkg::NUM_USER-1:0]     user_sel,
    output logic [periph_map_pkg::NUM_SIMPLE-1:0]   simple_sel,
    output periph_bus_pkg::bus_req_t                gpio_req,
    output periph_bus_pkg::bus_req_t                timer_req,
    output periph_bus_pkg::bus_req_t                pwm_req
);

    // Unselected slots see an idle request
    function automatic periph_bus_pkg::bus_req_t gate(
        input periph_bus_pkg::bus_req_t r,
        input logic                     sel
    );
        gate = r;
        if (!sel) begin
            gate.read  = periph_bus_pkg::acc_none;
            gate.write = periph_bus_pkg::acc_none;
        end
    endfunction

    // Bit 10 picks the simple space, 16 bytes per slot
    always_comb begin
        for (int u = 0; u < periph_map_pkg::NUM_USER; u++) begin
            user_sel[u] = !req.address[10] && (req.address[9:6] == 4'(u));
        end
        for (int s = 0; s < periph_map_pkg::NUM_SIMPLE; s++) begin
            simple_sel[s] = req.address[10] && (req.address[7:4] == 4'(s));
        end
    end

    assign gpio_req  = gate(req, user_sel[periph_map_pkg::SLOT_GPIO]);
    assign timer_req = gate(req, user_sel[periph_map_pkg::SLOT_TIMER]);
    assign pwm_req   = gate(req, simple_sel[periph_map_pkg::SIMPLE_PWM]);

endmodule

`default_nettype wire

// File: rtl/periph_gpio.sv
////////////////////////////////////////////////////////////
// GPIO peripheral
// Output register, input synchronizer and per-pin source
// select driving the output pins from any slot
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_gpio (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  periph_bus_pkg::bus_req_t                    req,
    input  logic [7:0]                                  ui_in,
    input  logic [periph_map_pkg::NUM_USER-1:0][7:0]    user_pins,
    input  logic [periph_map_pkg::NUM_SIMPLE-1:0][7:0]  simple_pins,
    output periph_bus_pkg::periph_resp_t                resp,
    output logic [7:0]                                  uo_out
);

    logic [7:0]                               gpio_out;
    logic [7:0]                               ui_in_meta;
    logic [7:0]                               ui_in_sync;
    logic [4:0]                               pin_sel [8];
    logic [periph_map_pkg::NUM_USER-1:0][7:0] user_src;
    logic [5:0]                               offset;
    logic                                     wr_en;
    logic                                     sel_hit;

    assign offset  = req.address[5:0];
    assign wr_en   = req.write != periph_bus_pkg::acc_none;
    // Select registers sit at base + 4 * pin
    assign sel_hit = (offset & ~6'h1c) == periph_map_pkg::GPIO_SEL_BASE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && offset == periph_map_pkg::GPIO_OUT_OFS) begin
            gpio_out <= req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        ui_in_meta <= ui_in;
        ui_in_sync <= ui_in_meta;
    end

    // Own pins fed back from the output register
    always_comb begin
        user_src = user_pins;
        user_src[periph_map_pkg::SLOT_GPIO] = gpio_out;
    end

    for (genvar p = 0; p < 8; p++) begin : g_pin
        logic pin_val;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                pin_sel[p] <= (p == 0) ? 5'(periph_map_pkg::SLOT_TIMER)
                                       : 5'(periph_map_pkg::SLOT_GPIO);
            end else if (wr_en && sel_hit && offset[4:2] == 3'(p)) begin
                pin_sel[p] <= req.wdata[4:0];
            end
        end

        always_comb begin
            pin_val = 1'b0;
            if (pin_sel[p][periph_map_pkg::SRC_SIMPLE_BIT]) begin
                for (int s = 0; s < periph_map_pkg::NUM_SIMPLE; s++) begin
                    if (pin_sel[p][3:0] == 4'(s)) begin
                        pin_val = simple_pins[s][p];
                    end
                end
            end else begin
                for (int u = 0; u < periph_map_pkg::NUM_USER; u++) begin
                    if (pin_sel[p][3:0] == 4'(u)) begin
                        pin_val = user_src[u][p];
                    end
                end
            end
        end

        assign uo_out[p] = pin_val;
    end

    always_comb begin
        resp.ready = 1'b1;
        resp.rdata = '0;
        if (offset == periph_map_pkg::GPIO_OUT_OFS) begin
            resp.rdata = {24'h0, gpio_out};
        end else if (offset == periph_map_pkg::GPIO_IN_OFS) begin
            resp.rdata = {24'h0, ui_in};
        end else if (offset == periph_map_pkg::GPIO_IN_OFS + 6'h04) begin
            // Synchronized copy of the inputs
            resp.rdata = {24'h0, ui_in_sync};
        end else if (sel_hit) begin
            resp.rdata = {27'h0, pin_sel[offset[4:2]]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/periph_timer.sv
////////////////////////////////////////////////////////////
// Compare timer
// 32-bit counter that wraps on the compare value and
// raises a sticky interrupt
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  periph_bus_pkg::bus_req_t     req,
    output periph_bus_pkg::periph_resp_t resp,
    output logic [7:0]                   pins,
    output logic                         irq
);

    periph_map_pkg::timer_state_e state;
    logic [31:0]                  cmp_q;
    logic [31:0]                  cnt_q;
    logic                         rd_ready;
    logic                         wr_en;
    logic [5:0]                   offset;

    // Narrow writes keep the upper bits
    function automatic logic [31:0] merge(
        input logic [31:0]                  old,
        input logic [31:0]                  data,
        input periph_bus_pkg::access_size_e size
    );
        case (size)
            periph_bus_pkg::acc_byte: merge = {old[31:8], data[7:0]};
            periph_bus_pkg::acc_half: merge = {old[31:16], data[15:0]};
            default:                  merge = data;
        endcase
    endfunction

    assign offset = req.address[5:0];
    assign wr_en  = req.write != periph_bus_pkg::acc_none;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= periph_map_pkg::tmr_idle;
            cmp_q    <= '0;
            cnt_q    <= '0;
            irq      <= 1'b0;
            rd_ready <= 1'b0;
        end else begin
            rd_ready <= req.read != periph_bus_pkg::acc_none;
            if (state == periph_map_pkg::tmr_running) begin
                if (cnt_q == cmp_q) begin
                    cnt_q <= '0;
                    irq   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 32'd1;
                end
            end
            if (wr_en && offset == periph_map_pkg::TMR_CMP_OFS) begin
                cmp_q <= merge(cmp_q, req.wdata, req.write);
            end
            // Register writes take priority over counting
            if (wr_en && offset == periph_map_pkg::TMR_CTRL_OFS) begin
                if (req.wdata[0]) begin
                    state <= periph_map_pkg::tmr_running;
                    cnt_q <= '0;
                end else begin
                    state <= periph_map_pkg::tmr_idle;
                end
                if (req.wdata[1]) begin
                    irq <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        resp.ready = (req.read == periph_bus_pkg::acc_none) || rd_ready;
        case (offset)
            periph_map_pkg::TMR_CMP_OFS:  resp.rdata = cmp_q;
            periph_map_pkg::TMR_CTRL_OFS:
                resp.rdata = {30'h0, irq, state == periph_map_pkg::tmr_running};
            periph_map_pkg::TMR_CNT_OFS:  resp.rdata = cnt_q;
            default:                      resp.rdata = '0;
        endcase
    end

    assign pins = {8{irq}};

endmodule

`default_nettype wire

// File: rtl/periph_pwm.sv
////////////////////////////////////////////////////////////
// Simple PWM peripheral
// 8-bit duty register against a free-running counter
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_pwm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       write,
    input  logic [3:0] address,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic [7:0] pins
);

    logic [7:0] duty;
    logic [7:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
            cnt  <= '0;
        end else begin
            cnt <= cnt + 8'd1;
            if (write && address == 4'h0) begin
                duty <= wdata;
            end
        end
    end

    // High for duty counts out of every 256
    assign pins  = {8{cnt < duty}};
    assign rdata = (address == 4'h0) ? duty : 8'h00;

endmodule

`default_nettype wire

// File: rtl/periph_read_return.sv
////////////////////////////////////////////////////////////
// Read return stage
// Muxes the selected slot, registers data_out and holds it
// until the core completes the read
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_read_return (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  periph_bus_pkg::bus_req_t              req,
    input  logic [periph_map_pkg::NUM_USER-1:0]   user_sel,
    input  logic [periph_map_pkg::NUM_SIMPLE-1:0] simple_sel,
    input  periph_bus_pkg::periph_resp_t          gpio_resp,
    input  periph_bus_pkg::periph_resp_t          timer_resp,
    input  logic [7:0]                            pwm_rdata,
    input  logic                                  data_read_complete,
    output logic [31:0]                           data_out,
    output logic                                  data_ready
);

    periph_bus_pkg::periph_resp_t sel_resp;
    logic                         active;
    logic                         last_active;
    logic                         is_read;
    logic                         hold;
    logic                         load;

    assign is_read = req.read != periph_bus_pkg::acc_none;
    assign active  = is_read || (req.write != periph_bus_pkg::acc_none);
    assign load    = !hold && sel_resp.ready && is_read;

    // Empty user slots never answer, empty simple slots read zero
    always_comb begin
        sel_resp = '0;
        if (req.address[10]) begin
            sel_resp.ready = 1'b1;
            if (simple_sel[periph_map_pkg::SIMPLE_PWM]) begin
                sel_resp.rdata = {24'h0, pwm_rdata};
            end
        end else if (user_sel[periph_map_pkg::SLOT_GPIO]) begin
            sel_resp = gpio_resp;
        end else if (user_sel[periph_map_pkg::SLOT_TIMER]) begin
            sel_resp = timer_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold        <= 1'b0;
            last_active <= 1'b0;
            data_ready  <= 1'b0;
        end else begin
            if (data_read_complete) begin
                hold <= 1'b0;
            end
            if (load) begin
                hold <= 1'b1;
            end
            last_active <= active;
            data_ready  <= last_active && active && sel_resp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_out <= sel_resp.rdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/periph_subsystem.sv
////////////////////////////////////////////////////////////
// Peripheral subsystem top level
// Decode, GPIO, timer, PWM and the read return stage
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_subsystem (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [7:0]                           ui_in,
    output logic [7:0]                           uo_out,
    input  periph_bus_pkg::bus_req_t             req,
    input  logic                                 data_read_complete,
    output logic [31:0]                          data_out,
    output logic                                 data_ready,
    output wire  [periph_map_pkg::NUM_USER-1:0]  user_interrupts
);

    periph_bus_pkg::bus_req_t                    gpio_req;
    periph_bus_pkg::bus_req_t                    timer_req;
    periph_bus_pkg::bus_req_t                    pwm_req;
    periph_bus_pkg::periph_resp_t                gpio_resp;
    periph_bus_pkg::periph_resp_t                timer_resp;
    logic [periph_map_pkg::NUM_USER-1:0]         user_sel;
    logic [periph_map_pkg::NUM_SIMPLE-1:0]       simple_sel;
    logic [7:0]                                  pwm_rdata;
    wire  [periph_map_pkg::NUM_USER-1:0][7:0]    user_pins;
    wire  [periph_map_pkg::NUM_SIMPLE-1:0][7:0]  simple_pins;

    // Empty slots drive no pins and no interrupts
    for (genvar u = 0; u < periph_map_pkg::NUM_USER; u++) begin : g_user_tie
        if (u != periph_map_pkg::SLOT_TIMER) begin : g_idle
            assign user_pins[u]       = '0;
            assign user_interrupts[u] = 1'b0;
        end
    end

    for (genvar s = 0; s < periph_map_pkg::NUM_SIMPLE; s++) begin : g_simple_tie
        if (s != periph_map_pkg::SIMPLE_PWM) begin : g_idle
            assign simple_pins[s] = '0;
        end
    end

    periph_decode u_decode (
        .req        (req),
        .user_sel   (user_sel),
        .simple_sel (simple_sel),
        .gpio_req   (gpio_req),
        .timer_req  (timer_req),
        .pwm_req    (pwm_req)
    );

    periph_gpio u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (gpio_req),
        .ui_in       (ui_in),
        .user_pins   (user_pins),
        .simple_pins (simple_pins),
        .resp        (gpio_resp),
        .uo_out      (uo_out)
    );

    periph_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (timer_req),
        .resp  (timer_resp),
        .pins  (user_pins[periph_map_pkg::SLOT_TIMER]),
        .irq   (user_interrupts[periph_map_pkg::SLOT_TIMER])
    );

    periph_pwm u_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (pwm_req.write != periph_bus_pkg::acc_none),
        .address (pwm_req.address[3:0]),
        .wdata   (pwm_req.wdata[7:0]),
        .rdata   (pwm_rdata),
        .pins    (simple_pins[periph_map_pkg::SIMPLE_PWM])
    );

    periph_read_return u_read_return (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .user_sel           (user_sel),
        .simple_sel         (simple_sel),
        .gpio_resp          (gpio_resp),
        .timer_resp         (timer_resp),
        .pwm_rdata          (pwm_rdata),
        .data_read_complete (data_read_complete),
        .data_out           (data_out),
        .data_ready         (data_ready)
    );

endmodule

`default_nettype wire

// File: testbench/periph_checker.sv
////////////////////////////////////////////////////////////
// Peripheral subsystem checker
// Compares bus reads, output pins, the timer interrupt and
// PWM duty against expected values and keeps the counts
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_checker (
    input  wire                                 clk,
    input  wire                                 data_ready,
    input  wire  [31:0]                         data_out,
    input  wire  [7:0]                          uo_out,
    input  wire  [periph_map_pkg::NUM_USER-1:0] user_interrupts,
    output int                                  pass_count,
    output int                                  fail_count
);

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    task automatic mark_pass(input int idx, input string what);
        pass_count++;
        $display("[PASS] vector %0d %s", idx, what);
    endtask

    task automatic mark_fail(input int idx, input string what);
        fail_count++;
        $display("[FAIL] %0t ns vector %0d %s", $time, idx, what);
    endtask

    // Handshake of one bus access
    task automatic wait_ready(input int idx, input int limit, output logic seen);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (data_ready !== 1'b1 && n < limit);
        seen = data_ready === 1'b1;
        if (!seen) begin
            fail_count++;
            $display("Vector %0d: data_ready did not rise within %0d cycles", idx, limit);
        end
    endtask

    task automatic check_write(input int idx);
        mark_pass(idx, "write acknowledged");
    endtask

    // Called while data_ready is high and data_out is held
    task automatic check_read(input int idx, input logic [31:0] expected);
        if (data_out !== expected) begin
            mark_fail(idx, $sformatf("read returned %h, expected %h", data_out, expected));
        end else begin
            mark_pass(idx, $sformatf("read %h", data_out));
        end
    endtask

    task automatic check_pins(input int idx, input logic [7:0] mask, input logic [7:0] expected);
        if ((uo_out & mask) !== expected) begin
            mark_fail(idx, $sformatf("uo_out %h under mask %h, expected %h",
                                     uo_out, mask, expected));
        end else begin
            mark_pass(idx, $sformatf("uo_out %h", uo_out));
        end
    endtask

    task automatic wait_irq(input int idx, input logic level, input int limit);
        int n;
        int stray;
        n = 0;
        stray = 0;
        while (user_interrupts[periph_map_pkg::SLOT_TIMER] !== level && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        // Only the timer slot has an interrupt source
        for (int b = 0; b < periph_map_pkg::NUM_USER; b++) begin
            if (b != periph_map_pkg::SLOT_TIMER && user_interrupts[b] !== 1'b0) begin
                stray++;
            end
        end
        if (user_interrupts[periph_map_pkg::SLOT_TIMER] !== level) begin
            fail_count++;
            $display("Vector %0d: the timer interrupt did not go to %0b within %0d cycles",
                     idx, level, limit);
        end else if (stray != 0) begin
            mark_fail(idx, $sformatf("user_interrupts %b, only the timer bit may be set",
                                     user_interrupts));
        end else begin
            mark_pass(idx, $sformatf("interrupt at %0b after %0d cycles", level, n));
        end
    endtask

    // One full counter period of the PWM
    task automatic count_pwm(input int idx, input logic [2:0] pin, input int expected);
        int highs;
        highs = 0;
        repeat (256) begin
            @(posedge clk);
            #2;
            if (uo_out[pin]) begin
                highs++;
            end
        end
        if (highs != expected) begin
            mark_fail(idx, $sformatf("pin %0d high for %0d of 256, expected %0d",
                                     pin, highs, expected));
        end else begin
            mark_pass(idx, $sformatf("pin %0d high for %0d of 256", pin, highs));
        end
    endtask

    task automatic report();
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    endtask

endmodule

`default_nettype wire

// File: testbench/periph_assert.sv
////////////////////////////////////////////////////////////
// Bus protocol assertions for the peripheral subsystem
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module periph_assert (
    input wire                           clk,
    input wire                           rst_n,
    input periph_bus_pkg::bus_req_t      req,
    input wire [31:0]                    data_out,
    input wire                           data_ready
);

    int   fail_total = 0;
    logic active;

    assign active = (req.read != periph_bus_pkg::acc_none) ||
                    (req.write != periph_bus_pkg::acc_none);

    a_ready_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !data_ready)
        else begin
            fail_total++;
            $error("data_ready high during reset");
        end

    // Read data must not move while the core is sampling it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (data_ready && req.read != periph_bus_pkg::acc_none) |=> $stable(data_out))
        else begin
            fail_total++;
            $error("data_out changed during a held read");
        end

    a_ready_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(data_ready) |-> ($past(active) && $past(active, 2)))
        else begin
            fail_total++;
            $error("data_ready rose without two cycles of request");
        end

endmodule

bind periph_subsystem periph_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .data_out   (data_out),
    .data_ready (data_ready)
);

`default_nettype wire

// File: testbench/tb_periph.sv
////////////////////////////////////////////////////////////
// Peripheral subsystem testbench
// Reads bus operations from a vector file, drives the core
// side of the bus and hands expected values to the checker
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module tb_periph;

    localparam int MAX_VEC     = 64;
    localparam int READY_LIMIT = 16;

    logic                                clk;
    logic                                rst_n;
    logic [7:0]                          ui_in;
    wire  [7:0]                          uo_out;
    periph_bus_pkg::bus_req_t            req;
    logic                                data_read_complete;
    wire  [31:0]                         data_out;
    wire                                 data_ready;
    wire  [periph_map_pkg::NUM_USER-1:0] user_interrupts;
    int                                  pass_count;
    int                                  fail_count;

    byte         vec_op   [MAX_VEC];
    logic [10:0] vec_addr [MAX_VEC];
    int          vec_size [MAX_VEC];
    logic [31:0] vec_data [MAX_VEC];
    logic [31:0] vec_exp  [MAX_VEC];
    int          num_vec = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    periph_subsystem UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .ui_in              (ui_in),
        .uo_out             (uo_out),
        .req                (req),
        .data_read_complete (data_read_complete),
        .data_out           (data_out),
        .data_ready         (data_ready),
        .user_interrupts    (user_interrupts)
    );

    periph_checker u_checker (
        .clk             (clk),
        .data_ready      (data_ready),
        .data_out        (data_out),
        .uo_out          (uo_out),
        .user_interrupts (user_interrupts),
        .pass_count      (pass_count),
        .fail_count      (fail_count)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Run limit grows with the number of vectors
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_vectors();
        int               fd;
        int               r;
        byte              op;
        logic [8*160-1:0] rest;
        fd = $fopen("testbench/periph_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file");
            $display("Test FAILED");
            $finish;
        end else begin
            r = $fscanf(fd, " %c", op);
            while (r == 1) begin
                if (op == "#" || num_vec >= MAX_VEC) begin
                    r = $fgets(rest, fd);
                end else begin
                    vec_op[num_vec] = op;
                    r = $fscanf(fd, " %h %d %h %h", vec_addr[num_vec], vec_size[num_vec],
                                vec_data[num_vec], vec_exp[num_vec]);
                    num_vec++;
                end
                r = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end
    endtask

    // Request stays up through the edge that samples data_ready
    // Reads end with a complete pulse
    task automatic run_access(input int idx, input logic is_read);
        periph_bus_pkg::access_size_e size;
        logic                         seen;
        size = periph_bus_pkg::access_size_e'(vec_size[idx][1:0]);
        req.address = vec_addr[idx];
        req.wdata   = is_read ? 32'h0 : vec_data[idx];
        req.write   = is_read ? periph_bus_pkg::acc_none : size;
        req.read    = is_read ? size : periph_bus_pkg::acc_none;
        u_checker.wait_ready(idx, READY_LIMIT, seen);
        if (seen) begin
            if (is_read) begin
                u_checker.check_read(idx, vec_exp[idx]);
            end else begin
                u_checker.check_write(idx);
            end
        end
        @(posedge clk);
        #2;
        req.write          = periph_bus_pkg::acc_none;
        req.read           = periph_bus_pkg::acc_none;
        data_read_complete = is_read;
        @(posedge clk);
        #2;
        data_read_complete = 1'b0;
    endtask

    initial begin
        rst_n              = 1'b0;
        ui_in              = '0;
        req.address        = '0;
        req.wdata          = '0;
        req.write          = periph_bus_pkg::acc_none;
        req.read           = periph_bus_pkg::acc_none;
        data_read_complete = 1'b0;
        load_vectors();
        cycle_limit = 300 * num_vec + 1000;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < num_vec; i++) begin
            case (vec_op[i])
                "W": run_access(i, 1'b0);
                "R": begin
                    // Read vectors also set the input pins
                    ui_in = vec_data[i][7:0];
                    run_access(i, 1'b1);
                end
                "O": u_checker.check_pins(i, vec_data[i][7:0], vec_exp[i][7:0]);
                "I": u_checker.wait_irq(i, vec_exp[i][0], vec_data[i]);
                "P": u_checker.count_pwm(i, vec_addr[i][2:0], vec_exp[i]);
                default: $display("Vector %0d has an unknown operation", i);
            endcase
        end
        repeat (4) @(posedge clk);
        u_checker.report();
        if (fail_count == 0 && pass_count == num_vec && UUT.u_assert.fail_total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/periph_bus_pkg.sv
rtl/periph_map_pkg.sv
rtl/periph_decode.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/periph_pwm.sv
rtl/periph_read_return.sv
rtl/periph_subsystem.sv
testbench/periph_checker.sv
testbench/periph_assert.sv
testbench/tb_periph.sv

// File: testbench/periph_vectors.txt
# op addr size data expected; size 0/1/2 = byte/half/word, other fields hex
# R sets ui_in from data, O checks uo_out&data, I waits data cycles, P counts pin addr
R 040 2 00000000 00000000
W 040 0 000000A5 00000000
R 040 2 00000000 000000A5
O 000 0 000000FE 000000A4
R 044 2 0000005A 0000005A
R 410 2 00000000 00000000
W 060 2 00000001 00000000
O 000 0 000000FF 000000A5
R 060 2 00000000 00000001
W 080 2 00000014 00000000
W 084 2 00000001 00000000
I 000 0 00000064 00000001
R 084 2 00000000 00000003
W 084 2 00000002 00000000
I 000 0 0000000A 00000000
R 084 2 00000000 00000000
W 070 0 00000010 00000000
W 400 0 00000040 00000000
P 004 0 00000000 00000040
R 400 2 00000000 00000040
W 080 2 FFFF0000 00000000
W 080 1 00001234 00000000
R 080 2 00000000 FFFF1234
